// ==== hw/rv_pkg.sv ====
package rv_pkg;

    parameter int XLEN       = 32;
    parameter int REG_ADDR_W = 5;

    typedef logic [XLEN-1:0]       xlen_t;     // data and instruction word
    typedef logic [REG_ADDR_W-1:0] reg_addr_t; // x0..x31
    typedef logic [6:0]            opcode_t;

    // opcode classes handled by the core
    localparam opcode_t OP_TYPE_R = 7'b0110011;
    localparam opcode_t OP_TYPE_I = 7'b0010011;
    localparam opcode_t OP_TYPE_B = 7'b1100011;
    localparam opcode_t OP_JAL    = 7'b1101111;
    localparam opcode_t OP_JALR   = 7'b1100111;
    localparam opcode_t OP_LUI    = 7'b0110111;
    localparam opcode_t OP_AUIPC  = 7'b0010111;
    localparam opcode_t OP_SYSTEM = 7'b1110011;

    localparam logic [2:0] F3_ADD_SUB = 3'b000; // also addi
    localparam logic [2:0] F3_BNE     = 3'b001;
    localparam logic [2:0] F3_JALR    = 3'b000;

    localparam logic [6:0] F7_ADD = 7'b0000000;
    localparam logic [6:0] F7_SUB = 7'b0100000;

    localparam xlen_t INST_EBREAK = 32'h0010_0073;

    typedef enum logic [1:0] {
        ALU_ADD = 2'd0,
        ALU_SUB = 2'd1,
        ALU_AND = 2'd2
    } alu_op_e;

    typedef enum logic [1:0] {
        IMM_I = 2'd0,
        IMM_B = 2'd1,
        IMM_J = 2'd2,
        IMM_U = 2'd3
    } imm_sel_e;

    // operand pair fed to the ALU
    typedef enum logic [1:0] {
        SRC_REG     = 2'd0, // rs1, rs2
        SRC_IMM     = 2'd1, // rs1, imm
        SRC_IMM_PC  = 2'd2, // pc, imm
        SRC_PC_FOUR = 2'd3  // pc, 4 (link value)
    } alu_src_e;

endpackage

// ==== hw/decode_if.sv ====
`timescale 1ns/1ps

interface decode_if;
    import rv_pkg::*;

    logic      reg_wen;   // write-back request from decode
    reg_addr_t reg_waddr; // rd
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;

    imm_sel_e  imm_sel;
    alu_op_e   alu_op;
    alu_src_e  alu_src;

    logic      branch;    // bne
    logic      jump;      // jal and jalr
    logic      jalr;      // target from rs1
    logic      ebreak;
    logic      illegal;

    modport dec (
        output reg_wen, reg_waddr, rs1_addr, rs2_addr,
        output imm_sel, alu_op, alu_src,
        output branch, jump, jalr, ebreak, illegal
    );

    modport rf (input reg_wen, reg_waddr, rs1_addr, rs2_addr);

    modport ex (input imm_sel, alu_op, alu_src);

    modport flow (input branch, jump, jalr, ebreak, illegal);

endinterface

// ==== hw/ctrl.sv ====
`timescale 1ns/1ps

module ctrl (
    input  rv_pkg::xlen_t inst,
    decode_if.dec         dec
);
    import rv_pkg::*;

    opcode_t    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_addr_t  rd;
    reg_addr_t  rs1;
    reg_addr_t  rs2;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign rd     = inst[11:7];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];

    always_comb begin
        dec.reg_wen   = 1'b0;
        dec.reg_waddr = '0;
        dec.rs1_addr  = '0;
        dec.rs2_addr  = '0;
        dec.imm_sel   = IMM_I;
        dec.alu_op    = ALU_AND; // idle value
        dec.alu_src   = SRC_REG;
        dec.branch    = 1'b0;
        dec.jump      = 1'b0;
        dec.jalr      = 1'b0;
        dec.ebreak    = 1'b0;
        dec.illegal   = 1'b0;

        case (opcode)
            OP_TYPE_R: begin
                dec.rs1_addr  = rs1;
                dec.rs2_addr  = rs2;
                dec.reg_waddr = rd;
                dec.alu_src   = SRC_REG;
                if (funct3 == F3_ADD_SUB && funct7 == F7_ADD) begin
                    dec.reg_wen = 1'b1;
                    dec.alu_op  = ALU_ADD;
                end else if (funct3 == F3_ADD_SUB && funct7 == F7_SUB) begin
                    dec.reg_wen = 1'b1;
                    dec.alu_op  = ALU_SUB;
                end else begin
                    dec.illegal = 1'b1; // no write on bad funct
                end
            end
            OP_TYPE_I: begin
                dec.rs1_addr  = rs1;
                dec.reg_waddr = rd;
                dec.imm_sel   = IMM_I;
                dec.alu_src   = SRC_IMM;
                dec.alu_op    = ALU_ADD;
                if (funct3 == F3_ADD_SUB) // addi only
                    dec.reg_wen = 1'b1;
                else
                    dec.illegal = 1'b1;
            end
            OP_TYPE_B: begin
                dec.rs1_addr = rs1;
                dec.rs2_addr = rs2;
                dec.imm_sel  = IMM_B;
                dec.alu_src  = SRC_REG;
                dec.alu_op   = ALU_SUB; // zero flag compares rs1, rs2
                if (funct3 == F3_BNE)
                    dec.branch = 1'b1;
                else
                    dec.illegal = 1'b1;
            end
            OP_JAL: begin
                dec.jump      = 1'b1;
                dec.reg_wen   = 1'b1;
                dec.reg_waddr = rd;
                dec.imm_sel   = IMM_J;
                dec.alu_op    = ALU_ADD;
                dec.alu_src   = SRC_PC_FOUR; // link = pc + 4
            end
            OP_JALR: begin
                dec.rs1_addr  = rs1;
                dec.reg_waddr = rd;
                dec.imm_sel   = IMM_I;
                dec.alu_op    = ALU_ADD;
                dec.alu_src   = SRC_PC_FOUR;
                if (funct3 == F3_JALR) begin
                    dec.jump    = 1'b1;
                    dec.jalr    = 1'b1;
                    dec.reg_wen = 1'b1;
                end else begin
                    dec.illegal = 1'b1;
                end
            end
            OP_LUI: begin
                dec.reg_wen   = 1'b1;
                dec.rs1_addr  = '0; // x0 + imm
                dec.reg_waddr = rd;
                dec.imm_sel   = IMM_U;
                dec.alu_op    = ALU_ADD;
                dec.alu_src   = SRC_IMM;
            end
            OP_AUIPC: begin
                dec.reg_wen   = 1'b1;
                dec.reg_waddr = rd;
                dec.imm_sel   = IMM_U;
                dec.alu_op    = ALU_ADD;
                dec.alu_src   = SRC_IMM_PC; // pc + imm
            end
            OP_SYSTEM: begin
                if (inst == INST_EBREAK)
                    dec.ebreak = 1'b1;
                else
                    dec.illegal = 1'b1; // ecall, csr and friends
            end
            default: dec.illegal = 1'b1;
        endcase
    end

endmodule

// ==== hw/imm_gen.sv ====
`timescale 1ns/1ps

module imm_gen (
    input  rv_pkg::xlen_t inst,
    decode_if.ex          ex,
    output rv_pkg::xlen_t imm
);
    import rv_pkg::*;

    logic sign;

    assign sign = inst[31]; // sign bit sits at 31 in every format

    always_comb begin
        case (ex.imm_sel)
            IMM_I: begin
                imm = {{20{sign}}, inst[31:20]};
            end
            IMM_B: begin
                // offset in multiples of two
                imm = {{19{sign}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            end
            IMM_J: begin
                imm = {{11{sign}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            IMM_U: begin
                imm = {inst[31:12], 12'b0}; // low bits cleared
            end
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

// ==== hw/alu.sv ====
`timescale 1ns/1ps

module alu (
    input  rv_pkg::xlen_t pc,
    input  rv_pkg::xlen_t rs1_data,
    input  rv_pkg::xlen_t rs2_data,
    input  rv_pkg::xlen_t imm,
    decode_if.ex          ex,
    output rv_pkg::xlen_t result,
    output logic          zero
);
    import rv_pkg::*;

    xlen_t op_a;
    xlen_t op_b;

    always_comb begin
        case (ex.alu_src)
            SRC_REG: begin
                op_a = rs1_data;
                op_b = rs2_data;
            end
            SRC_IMM: begin
                op_a = rs1_data;
                op_b = imm;
            end
            SRC_IMM_PC: begin
                op_a = pc;
                op_b = imm;
            end
            default: begin // SRC_PC_FOUR
                op_a = pc;
                op_b = 32'd4;
            end
        endcase
    end

    always_comb begin
        case (ex.alu_op)
            ALU_ADD: result = op_a + op_b;
            ALU_SUB: result = op_a - op_b;
            ALU_AND: result = op_a & op_b;
            default: result = '0;
        endcase
    end

    assign zero = (result == '0); // bne taken when low

endmodule

// ==== hw/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              halted,
    decode_if.rf              rf,
    input  rv_pkg::xlen_t     wdata,
    output rv_pkg::xlen_t     rs1_data,
    output rv_pkg::xlen_t     rs2_data,
    output logic              wb_en,
    output rv_pkg::reg_addr_t wb_addr,
    output rv_pkg::xlen_t     wb_data
);
    import rv_pkg::*;

    xlen_t regs [1:31]; // x0 has no storage

    // commit port shows the write landing at the next edge
    assign wb_en   = rf.reg_wen && rst_n && !halted && (rf.reg_waddr != '0);
    assign wb_addr = rf.reg_waddr;
    assign wb_data = wdata;

    always_ff @(posedge clk) begin
        if (wb_en) begin
            regs[wb_addr] <= wb_data;
        end
    end

    // x0 reads as zero
    assign rs1_data = (rf.rs1_addr == '0) ? '0 : regs[rf.rs1_addr];
    assign rs2_data = (rf.rs2_addr == '0) ? '0 : regs[rf.rs2_addr];

    a_wb_data_known: assert property (
        @(posedge clk) wb_en |-> !$isunknown(wb_data)
    );

endmodule

// ==== hw/pc_unit.sv ====
`timescale 1ns/1ps

module pc_unit #(
    parameter rv_pkg::xlen_t RESET_PC = '0
) (
    input  logic          clk,
    input  logic          rst_n,
    decode_if.flow        flow,
    input  rv_pkg::xlen_t imm,
    input  rv_pkg::xlen_t rs1_data,
    input  logic          zero,
    output rv_pkg::xlen_t pc,
    output logic          halted,
    output logic          illegal_seen
);
    import rv_pkg::*;

    xlen_t pc_next;
    logic  trap;

    assign trap = flow.ebreak || flow.illegal;

    always_comb begin
        if (trap)
            pc_next = pc; // stay on the trapping instruction
        else if (flow.jalr)
            pc_next = (rs1_data + imm) & ~32'd1;
        else if (flow.jump || (flow.branch && !zero))
            pc_next = pc + imm;
        else
            pc_next = pc + 32'd4;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc           <= RESET_PC;
            halted       <= 1'b0;
            illegal_seen <= 1'b0;
        end else if (!halted) begin
            pc <= pc_next;
            if (trap)
                halted <= 1'b1; // sticky until reset
            if (flow.illegal)
                illegal_seen <= 1'b1;
        end
    end

    a_pc_aligned: assert property (
        @(posedge clk) disable iff (!rst_n) pc[1:0] == 2'b00
    );

endmodule

// ==== hw/rv_core.sv ====
`timescale 1ns/1ps

module rv_core #(
    parameter rv_pkg::xlen_t RESET_PC = '0
) (
    input  logic              clk,
    input  logic              rst_n,
    input  rv_pkg::xlen_t     inst,
    output rv_pkg::xlen_t     inst_addr,
    output logic              wb_en,
    output rv_pkg::reg_addr_t wb_addr,
    output rv_pkg::xlen_t     wb_data,
    output logic              halted,
    output logic              illegal
);
    import rv_pkg::*;

    xlen_t pc;
    xlen_t rs1_data;
    xlen_t rs2_data;
    xlen_t imm;
    xlen_t alu_result;
    logic  zero;

    decode_if dec_bus ();

    assign inst_addr = pc; // fetch straight from the pc register

    ctrl u_ctrl (
        .inst (inst),
        .dec  (dec_bus.dec)
    );

    imm_gen u_imm_gen (
        .inst (inst),
        .ex   (dec_bus.ex),
        .imm  (imm)
    );

    alu u_alu (
        .pc       (pc),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .imm      (imm),
        .ex       (dec_bus.ex),
        .result   (alu_result),
        .zero     (zero)
    );

    reg_file u_reg_file (
        .clk      (clk),
        .rst_n    (rst_n),
        .halted   (halted),
        .rf       (dec_bus.rf),
        .wdata    (alu_result),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb_en    (wb_en),
        .wb_addr  (wb_addr),
        .wb_data  (wb_data)
    );

    pc_unit #(
        .RESET_PC (RESET_PC)
    ) u_pc_unit (
        .clk          (clk),
        .rst_n        (rst_n),
        .flow         (dec_bus.flow),
        .imm          (imm),
        .rs1_data     (rs1_data),
        .zero         (zero),
        .pc           (pc),
        .halted       (halted),
        .illegal_seen (illegal)
    );

endmodule

// ==== testbench/tb_rv_core.sv ====
`timescale 1ns/1ps

module tb_rv_core;

    localparam logic [31:0] RESET_PC = 32'h0000_0000;
    localparam int CLK_PERIOD    = 8;
    localparam int RESET_CYCLES  = 4;
    localparam int MEM_WORDS     = 64;
    localparam logic [31:0] EBREAK = 32'h0010_0073;
    // one cycle per instruction plus the halt cycle, per program run
    localparam int TEST_CYCLES   = 2 * 15 + 7 + 13 + 8 + 12 + 6;
    localparam int RESET_COUNT   = 9;
    localparam int MARGIN_CYCLES = 20;
    localparam int WATCHDOG_NS   = (TEST_CYCLES + RESET_COUNT * (RESET_CYCLES + 2)
                                    + MARGIN_CYCLES) * CLK_PERIOD;

    logic        clk;
    logic        rst_n;
    logic [31:0] inst;
    logic [31:0] inst_addr;
    logic        wb_en;
    logic [4:0]  wb_addr;
    logic [31:0] wb_data;
    logic        halted;
    logic        illegal;

    logic [31:0] prog_mem [0:MEM_WORDS-1];
    int          load_ptr;
    integer      seed = 32'h564baf94;

    logic [31:0] model_pc;
    logic [31:0] model_regs [0:31];
    logic        model_halted;
    logic        model_illegal;

    rv_core #(
        .RESET_PC (RESET_PC)
    ) UUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .inst      (inst),
        .inst_addr (inst_addr),
        .wb_en     (wb_en),
        .wb_addr   (wb_addr),
        .wb_data   (wb_data),
        .halted    (halted),
        .illegal   (illegal)
    );

    // memory answers the fetch in the same cycle
    assign inst = $isunknown(inst_addr) ? 32'h0 :
                  (inst_addr < MEM_WORDS * 4) ? prog_mem[inst_addr[7:2]] : 32'h0;

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the core did not halt within %0d ns", WATCHDOG_NS);
        $display(">>> FAIL");
        $fatal(1, "watchdog expired");
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Fail %s: got 0x%08h, expected 0x%08h (model pc 0x%08h)",
                     name, actual, expected, model_pc);
            $display(">>> FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                          input logic [4:0] rs2, rs1, rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_addi(input logic [4:0] rd, rs1,
                                             input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] enc_jalr(input logic [4:0] rd, rs1,
                                             input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b1100111};
    endfunction

    function automatic logic [31:0] enc_lui(input logic [4:0] rd, input logic [19:0] up);
        return {up, rd, 7'b0110111};
    endfunction

    function automatic logic [31:0] enc_auipc(input logic [4:0] rd, input logic [19:0] up);
        return {up, rd, 7'b0010111};
    endfunction

    function automatic logic [31:0] enc_bne(input logic [4:0] rs1, rs2,
                                            input logic [31:0] off);
        return {off[12], off[10:5], rs2, rs1, 3'b001, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_jal(input logic [4:0] rd, input logic [31:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [31:0] fetch(input logic [31:0] addr);
        if (addr >= MEM_WORDS * 4)
            return 32'h0;
        return prog_mem[addr[7:2]];
    endfunction

    task automatic clear_program;
        for (int i = 0; i < MEM_WORDS; i++)
            prog_mem[i] = {i[24:0], 7'b0000000}; // opcode 0 traps as illegal
        load_ptr = 0;
    endtask

    task automatic emit(input logic [31:0] word);
        prog_mem[load_ptr] = word;
        load_ptr++;
    endtask

    task automatic emit_li(input logic [4:0] rd, input logic [31:0] value);
        logic [31:0] upper;
        upper = value + 32'h800; // undo sign extension of the low part
        emit(enc_lui(rd, upper[31:12]));
        emit(enc_addi(rd, rd, value[11:0]));
    endtask

    task automatic start_program;
        @(posedge clk);
        #1;
        clear_program();
    endtask

    task automatic apply_reset;
        @(posedge clk);
        #1 rst_n = 1'b0;
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            check_value("wb_en", wb_en, 1'b0); // no commit while in reset
            @(posedge clk);
        end
        #1 rst_n = 1'b1;
    endtask

    // compare one cycle against the model, then advance the model
    task automatic check_cycle;
        logic [31:0] w;
        logic [31:0] r1;
        logic [31:0] r2;
        logic [31:0] imm_i;
        logic [31:0] imm_b;
        logic [31:0] imm_j;
        logic [31:0] imm_u;
        logic [31:0] data;
        logic [31:0] next_pc;
        logic [4:0]  rd;
        logic        wen;
        logic        bad;
        logic        trap;
        check_value("halted", halted, model_halted);
        check_value("illegal", illegal, model_illegal);
        check_value("inst_addr", inst_addr, model_pc);
        if (model_halted) begin
            check_value("wb_en", wb_en, 1'b0);
        end else begin
            w       = fetch(model_pc);
            rd      = w[11:7];
            r1      = (w[19:15] == 0) ? 32'h0 : model_regs[w[19:15]];
            r2      = (w[24:20] == 0) ? 32'h0 : model_regs[w[24:20]];
            imm_i   = {{20{w[31]}}, w[31:20]};
            imm_b   = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            imm_j   = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            imm_u   = {w[31:12], 12'h000};
            next_pc = model_pc + 4;
            data    = 32'h0;
            wen     = 1'b0;
            bad     = 1'b0;
            trap    = 1'b0;
            case (w[6:0])
                7'b0110011: begin // add, sub
                    wen = (w[14:12] == 3'b000) && (w[31:25] == 7'h00 || w[31:25] == 7'h20);
                    bad = !wen;
                    data = (w[31:25] == 7'h20) ? r1 - r2 : r1 + r2;
                end
                7'b0010011: begin
                    wen  = (w[14:12] == 3'b000);
                    bad  = !wen;
                    data = r1 + imm_i;
                end
                7'b1100011: begin
                    bad = (w[14:12] != 3'b001);
                    if (r1 != r2)
                        next_pc = model_pc + imm_b;
                end
                7'b1101111: begin
                    wen     = 1'b1;
                    data    = model_pc + 4;
                    next_pc = model_pc + imm_j;
                end
                7'b1100111: begin
                    wen     = (w[14:12] == 3'b000);
                    bad     = !wen;
                    data    = model_pc + 4;
                    next_pc = (r1 + imm_i) & 32'hffff_fffe;
                end
                7'b0110111: begin
                    wen  = 1'b1;
                    data = imm_u;
                end
                7'b0010111: begin
                    wen  = 1'b1;
                    data = model_pc + imm_u;
                end
                7'b1110011: begin
                    trap = 1'b1;
                    bad  = (w != EBREAK);
                end
                default: bad = 1'b1;
            endcase
            trap = trap || bad;
            wen  = wen && !trap && (rd != 0); // x0 writes never commit
            check_value("wb_en", wb_en, wen);
            if (wen) begin
                check_value("wb_addr", wb_addr, rd);
                check_value("wb_data", wb_data, data);
                model_regs[rd] = data;
            end
            if (trap) begin
                model_halted  = 1'b1;
                model_illegal = model_illegal || bad;
            end else begin
                model_pc = next_pc;
            end
        end
    endtask

    task automatic run_to_halt;
        model_pc      = RESET_PC;
        model_halted  = 1'b0;
        model_illegal = 1'b0;
        while (!model_halted) begin
            @(negedge clk);
            check_cycle();
        end
        @(negedge clk);
        check_cycle(); // halted is visible one cycle after the trap
    endtask

    task automatic test_arith;
        logic [31:0] a;
        logic [31:0] b;
        a = $random(seed);
        b = $random(seed);
        start_program();
        emit_li(5'd1, a);
        emit_li(5'd2, b);
        emit(enc_r(7'h00, 3'b000, 5'd2, 5'd1, 5'd3)); // add
        emit(enc_r(7'h20, 3'b000, 5'd2, 5'd1, 5'd4)); // sub
        emit(enc_r(7'h20, 3'b000, 5'd1, 5'd2, 5'd5));
        emit(enc_addi(5'd6, 5'd1, 12'hfff));          // -1
        emit(enc_addi(5'd7, 5'd2, 12'h800));          // -2048
        emit(enc_addi(5'd8, 5'd0, 12'h7ff));
        emit(enc_r(7'h00, 3'b000, 5'd2, 5'd1, 5'd0)); // to x0, no commit
        emit(enc_addi(5'd0, 5'd1, 12'd5));
        emit(enc_r(7'h00, 3'b000, 5'd4, 5'd3, 5'd9));
        emit(EBREAK);
        apply_reset();
        run_to_halt();
    endtask

    task automatic test_upper;
        logic [31:0] u1;
        logic [31:0] u2;
        u1 = $random(seed);
        u2 = $random(seed);
        start_program();
        emit(enc_lui(5'd1, u1[19:0]));
        emit(enc_lui(5'd2, 20'hfffff));
        emit(enc_addi(5'd0, 5'd0, 12'd0)); // nop so auipc sees a nonzero pc
        emit(enc_auipc(5'd3, u2[19:0]));
        emit(enc_auipc(5'd4, 20'h00000));
        emit(EBREAK);
        apply_reset();
        run_to_halt();
    endtask

    task automatic test_branch;
        start_program();
        emit(enc_addi(5'd1, 5'd0, 12'd5));
        emit(enc_addi(5'd2, 5'd0, 12'd5));
        emit(enc_bne(5'd1, 5'd2, 8));      // equal, falls through
        emit(enc_addi(5'd2, 5'd0, 12'd8));
        emit(enc_bne(5'd1, 5'd2, 12));     // forward taken
        emit(enc_addi(5'd5, 5'd0, 12'd1));
        emit(EBREAK);
        emit(enc_addi(5'd1, 5'd1, 12'd1)); // loop body at 28
        emit(enc_bne(5'd1, 5'd2, -4));     // backward until x1 == 8
        emit(EBREAK);
        apply_reset();
        run_to_halt();
    endtask

    task automatic test_jump;
        start_program();
        emit(enc_jal(5'd1, 12));
        emit(enc_jalr(5'd7, 5'd1, 12'd32));
        emit(EBREAK);
        emit(enc_addi(5'd5, 5'd0, 12'd25)); // odd base for jalr
        emit(enc_jalr(5'd6, 5'd5, 12'd4)); // bit 0 cleared, lands on 28
        emit(EBREAK);
        emit(EBREAK);
        emit(enc_jal(5'd0, -24));
        emit(EBREAK);
        emit(enc_jal(5'd8, 8));
        emit(EBREAK);
        emit(EBREAK);
        apply_reset();
        run_to_halt();
    endtask

    task automatic test_halt;
        start_program();
        emit(enc_addi(5'd1, 5'd0, 12'd1));
        emit(EBREAK);
        apply_reset();
        run_to_halt();
        @(posedge clk);
        #1;
        prog_mem[1] = enc_addi(5'd9, 5'd0, 12'd7); // a writing word under the held pc
        repeat (4) begin
            @(negedge clk);
            check_cycle(); // pc holds, nothing commits
        end
        @(posedge clk);
        #1;
        prog_mem[1] = EBREAK;
        apply_reset();
        run_to_halt();
    endtask

    task automatic test_illegal;
        start_program();
        emit(enc_addi(5'd1, 5'd0, 12'd1));
        emit(enc_r(7'h00, 3'b111, 5'd2, 5'd1, 5'd3)); // and is not supported
        apply_reset();
        run_to_halt();
        start_program();
        emit(enc_addi(5'd1, 5'd0, 12'd2));
        emit(32'h0000_2083); // lw, unknown opcode class
        apply_reset();
        run_to_halt();
    endtask

    initial begin
        rst_n = 1'b0;
        for (int i = 0; i < 32; i++)
            model_regs[i] = 32'h0;
        model_pc      = RESET_PC;
        model_halted  = 1'b0;
        model_illegal = 1'b0;
        clear_program();
        test_arith();
        test_arith();
        test_upper();
        test_branch();
        test_jump();
        test_halt();
        test_illegal();
        $display(">>> PASS");
        $finish;
    end

endmodule

// ==== project.f ====
hw/rv_pkg.sv
hw/decode_if.sv
hw/ctrl.sv
hw/imm_gen.sv
hw/alu.sv
hw/reg_file.sv
hw/pc_unit.sv
hw/rv_core.sv
testbench/tb_rv_core.sv

// ==== Bender.yml ====
package:
  name: rv_core

sources:
  - files:
      - hw/rv_pkg.sv
      - hw/decode_if.sv
      - hw/ctrl.sv
      - hw/imm_gen.sv
      - hw/alu.sv
      - hw/reg_file.sv
      - hw/pc_unit.sv
      - hw/rv_core.sv
  - target: test
    files:
      - testbench/tb_rv_core.sv
